// File: Bender.yml
package:
  name: dns_guard

sources:
  - hw/dns_guard_pkg.sv
  - hw/dns_resp_parser.sv
  - hw/icmp_unreach_parser.sv
  - hw/db_req_arbiter.sv
  - hw/drop_delay_line.sv
  - hw/dns_guard_top.sv
  - target: simulation
    files:
      - dv/dns_guard_asserts.sv
      - dv/dns_guard_tb.sv

// File: dv/dns_guard_asserts.sv
// bound assertions on the database request port and the tx stream
`default_nettype none

module dns_guard_asserts (
	input wire logic                       clk156,
	input wire logic                       eth_rst,
	input wire logic                       fire0,
	input wire logic                       db_req_valid,
	input wire dns_guard_pkg::lookup_req_t db_req,
	input wire dns_guard_pkg::beat_t       tx
);
	timeunit 1ns;
	timeprecision 1ps;
	import dns_guard_pkg::*;

	int unsigned fail_count = 0;

	// requests are one-cycle strobes
	assert property (@(posedge clk156) disable iff (eth_rst) db_req_valid |=> !db_req_valid)
	else begin
		fail_count++;
		$error("db_req_valid high for two cycles in a row");
	end

	// delay line stays flushed while reset holds
	assert property (@(posedge clk156) eth_rst ##1 eth_rst |-> tx == '0)
	else begin
		fail_count++;
		$error("tx not zero during reset");
	end

	// a port 0 fire always wins the database port
	assert property (@(posedge clk156) disable iff (eth_rst) fire0 |=> db_req.op != OP_INSERT)
	else begin
		fail_count++;
		$error("insert request sent in the cycle after a port 0 fire");
	end

endmodule

bind dns_guard_top dns_guard_asserts dns_guard_asserts_i (
	.clk156       (clk156),
	.eth_rst      (eth_rst),
	.fire0        (fire0),
	.db_req_valid (db_req_valid),
	.db_req       (db_req),
	.tx           (tx)
);

`default_nettype wire

// File: dv/dns_guard_tb.sv
// testbench with clock, reset, DUT, LFSR, frame builders, compare tasks, directed tests, timeout
`default_nettype none

module dns_guard_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import dns_guard_pkg::*;

	localparam int delay_stages = 12;
	localparam int frame_beats  = 12;
	localparam int drain_cycles = 20;
	// frame start to request on each port
	localparam int req_lat0     = 8;
	localparam int req_lat1     = 12;
	localparam int num_frames   = 13;
	localparam int max_cycles   = num_frames * (frame_beats + drain_cycles) + 200;

	logic        clk156;
	logic        eth_rst;
	beat_t       rx0;
	beat_t       rx1;
	db_reply_t   db_reply;
	logic        db_req_valid;
	lookup_req_t db_req;
	beat_t       tx;

	logic [31:0] lfsr_state = 32'h618354d7;
	logic [7:0]  frm0 [frame_beats*8];
	logic [7:0]  frm1 [frame_beats*8];
	beat_t       exp_tx_q [$];
	lookup_req_t exp_req_q [$];
	int          exp_due_q [$];
	int          cyc = 0;
	logic        tb_in_frame = 1'b0;
	logic        erasing = 1'b0;
	int          mismatch_cnt = 0;
	int          fail_cnt = 0;

	dns_guard_top dns_guard_top_i (
		.clk156       (clk156),
		.eth_rst      (eth_rst),
		.rx0          (rx0),
		.rx1          (rx1),
		.db_reply     (db_reply),
		.db_req_valid (db_req_valid),
		.db_req       (db_req),
		.tx           (tx)
	);

	initial begin
		clk156 = 1'b0;
		forever #5 clk156 = ~clk156;
	end

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b) begin
			lfsr_state = lfsr_state ^ 32'h80200003;
		end
		return b;
	endfunction

	function automatic logic [7:0] next_byte();
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < 8; i++) begin
			v = {v[6:0], lfsr_bit()};
		end
		return v;
	endfunction

	// big endian field write into one of the frame buffers
	function automatic void put_bytes(input logic port1, input int pos,
			input logic [31:0] val, input int n);
		for (int i = 0; i < n; i++) begin
			if (port1) begin
				frm1[pos+i] = val[8*(n-1-i) +: 8];
			end else begin
				frm0[pos+i] = val[8*(n-1-i) +: 8];
			end
		end
	endfunction

	task automatic build_ip_frame(input logic [7:0] proto, input logic [31:0] sip,
			input logic [31:0] dip, input logic [15:0] sport, input logic [15:0] dport,
			input logic qr);
		for (int i = 0; i < frame_beats*8; i++) begin
			frm0[i] = next_byte();
		end
		put_bytes(1'b0, 12, 32'h0800, 2);
		put_bytes(1'b0, 23, proto, 1);
		put_bytes(1'b0, 26, sip, 4);
		put_bytes(1'b0, 30, dip, 4);
		put_bytes(1'b0, 34, sport, 2);
		put_bytes(1'b0, 36, dport, 2);
		frm0[44][7] = qr;
	endtask

	// icmp unreachable quoting an ip/udp header
	task automatic build_icmp_frame(input logic [7:0] code, input logic [31:0] qsip,
			input logic [31:0] qdip, input logic [15:0] qsport, input logic [15:0] qdport);
		for (int i = 0; i < frame_beats*8; i++) begin
			frm1[i] = next_byte();
		end
		put_bytes(1'b1, 12, 32'h0800, 2);
		put_bytes(1'b1, 23, 32'h01, 1);
		put_bytes(1'b1, 34, 32'h03, 1);
		put_bytes(1'b1, 35, code, 1);
		put_bytes(1'b1, 54, qsip, 4);
		put_bytes(1'b1, 58, qdip, 4);
		put_bytes(1'b1, 62, qsport, 2);
		put_bytes(1'b1, 64, qdport, 2);
	endtask

	function automatic beat_t beat_of(input logic port1, input int k);
		beat_t b;
		b = '0;
		b.tvalid = 1'b1;
		b.tkeep = 8'hff;
		b.tlast = (k == frame_beats - 1);
		for (int j = 0; j < 8; j++) begin
			b.tdata[8*j +: 8] = port1 ? frm1[8*k + j] : frm0[8*k + j];
		end
		return b;
	endfunction

	function automatic lookup_req_t make_req(input db_op_e op, input logic [31:0] sip,
			input logic [31:0] dip, input logic [15:0] dport);
		lookup_req_t r;
		r.op = op;
		r.key.src_ip = sip;
		r.key.dst_ip = dip;
		r.key.dst_port = dport;
		r.key.rsvd = '0;
		return r;
	endfunction

	task automatic idle(input int n);
		repeat (n) @(posedge clk156);
	endtask

	// back-to-back beats with the expected request queued at beat 0
	task automatic send_frame(input logic port1, input logic want_req, input lookup_req_t req);
		for (int k = 0; k < frame_beats; k++) begin
			@(posedge clk156);
			if (k == 0 && want_req) begin
				exp_req_q.push_back(req);
				exp_due_q.push_back(cyc + 1 + (port1 ? req_lat1 : req_lat0));
			end
			if (port1) begin
				rx1 <= beat_of(1'b1, k);
			end else begin
				rx0 <= beat_of(1'b0, k);
			end
		end
		@(posedge clk156);
		if (port1) begin
			rx1 <= '0;
		end else begin
			rx0 <= '0;
		end
	endtask

	task automatic check_beat(input beat_t got, input beat_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: tx beat %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_req(input lookup_req_t got, input lookup_req_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: db_req %h, expected %h", $time, got, exp);
		end
	endtask

	// tx model and request check sampled mid-cycle
	always @(negedge clk156) begin
		logic sof_seen;
		int   n;
		cyc++;
		if (!eth_rst) begin
			sof_seen = rx0.tvalid && !tb_in_frame;
			if (rx0.tvalid) begin
				tb_in_frame = !rx0.tlast;
			end
			if (sof_seen) begin
				erasing = 1'b0;
			end
			if (erasing) begin
				exp_tx_q.push_back('0);
			end else begin
				exp_tx_q.push_back(rx0);
			end
			// block verdict wipes the beats still in flight
			if (db_reply.valid && db_reply.flag[2:1] == 2'b10) begin
				n = exp_tx_q.size();
				for (int i = n - delay_stages; i < n - 1; i++) begin
					if (i >= 0) begin
						exp_tx_q[i] = '0;
					end
				end
				if (!sof_seen) begin
					exp_tx_q[n-1] = '0;
					erasing = 1'b1;
				end
			end
			if (exp_tx_q.size() > delay_stages) begin
				check_beat(tx, exp_tx_q.pop_front());
			end
			if (db_req_valid) begin
				if (exp_req_q.size() == 0) begin
					fail_cnt++;
					$display("unexpected database request at %0t", $time);
				end else begin
					if (exp_due_q[0] != cyc) begin
						mismatch_cnt++;
						$display("MISMATCH at %0t: request in cycle %0d, expected %0d",
							$time, cyc, exp_due_q[0]);
					end
					check_req(db_req, exp_req_q.pop_front());
					void'(exp_due_q.pop_front());
				end
			end else if (exp_due_q.size() > 0 && exp_due_q[0] <= cyc) begin
				fail_cnt++;
				$display("database request due in cycle %0d did not appear", exp_due_q[0]);
				void'(exp_due_q.pop_front());
				void'(exp_req_q.pop_front());
			end
		end
	end

	task automatic test_pass_through();
		build_ip_frame(8'h06, 32'h0a000001, 32'h0a000002, 16'd80, 16'd443, 1'b1);
		send_frame(1'b0, 1'b0, '0);
		idle(drain_cycles);
	endtask

	task automatic test_dns_response();
		build_ip_frame(8'h11, 32'h08080808, 32'hc0a80010, 16'd53, 16'd40001, 1'b1);
		send_frame(1'b0, 1'b1, make_req(OP_LOOKUP, 32'h08080808, 32'hc0a80010, 16'd40001));
		idle(drain_cycles);
		build_ip_frame(8'h11, 32'h01010101, 32'hc0a80020, 16'd53, 16'd40002, 1'b0);
		send_frame(1'b0, 1'b1, make_req(OP_NONE, 32'h01010101, 32'hc0a80020, 16'd40002));
		idle(drain_cycles);
		build_ip_frame(8'h11, 32'h01010101, 32'hc0a80020, 16'd5353, 16'd40003, 1'b1);
		send_frame(1'b0, 1'b0, '0);
		idle(drain_cycles);
	endtask

	task automatic test_icmp_unreach();
		build_icmp_frame(8'd3, 32'hc0a80001, 32'h5db8d822, 16'd53, 16'd33000);
		send_frame(1'b1, 1'b1, make_req(OP_INSERT, 32'hc0a80001, 32'h5db8d822, 16'd33000));
		idle(drain_cycles);
		build_icmp_frame(8'd10, 32'hc0a80002, 32'h5db8d823, 16'd53, 16'd33001);
		send_frame(1'b1, 1'b1, make_req(OP_INSERT, 32'hc0a80002, 32'h5db8d823, 16'd33001));
		idle(drain_cycles);
		build_icmp_frame(8'd1, 32'hc0a80003, 32'h5db8d824, 16'd53, 16'd33002);
		send_frame(1'b1, 1'b0, '0);
		idle(drain_cycles);
		build_icmp_frame(8'd3, 32'hc0a80004, 32'h5db8d825, 16'd5353, 16'd33003);
		send_frame(1'b1, 1'b0, '0);
		idle(drain_cycles);
	endtask

	// block reply at beat 3 of the second frame, the oldest erased beat is beat 5 of the first
	task automatic test_block();
		fork
			begin
				build_ip_frame(8'h06, 32'h0a000003, 32'h0a000004, 16'd1000, 16'd2000, 1'b0);
				send_frame(1'b0, 1'b0, '0);
				build_ip_frame(8'h06, 32'h0a000005, 32'h0a000006, 16'd1001, 16'd2001, 1'b0);
				send_frame(1'b0, 1'b0, '0);
			end
			begin
				idle(17);
				db_reply <= '{valid: 1'b1, flag: 4'b0100};
				idle(1);
				db_reply <= '0;
			end
		join
		idle(drain_cycles);
		// next frame passes and a non-block reply leaves it alone
		fork
			begin
				build_ip_frame(8'h06, 32'h0a000007, 32'h0a000008, 16'd1002, 16'd2002, 1'b0);
				send_frame(1'b0, 1'b0, '0);
			end
			begin
				idle(6);
				db_reply <= '{valid: 1'b1, flag: 4'b0010};
				idle(1);
				db_reply <= '0;
			end
		join
		idle(drain_cycles);
	endtask

	// both parsers fire together and port 0 wins
	task automatic test_priority();
		build_icmp_frame(8'd3, 32'hc0a80009, 32'h5db8d830, 16'd53, 16'd34000);
		build_ip_frame(8'h11, 32'h09090909, 32'hc0a80030, 16'd53, 16'd40010, 1'b1);
		fork
			send_frame(1'b1, 1'b0, '0);
			begin
				idle(4);
				send_frame(1'b0, 1'b1,
					make_req(OP_LOOKUP, 32'h09090909, 32'hc0a80030, 16'd40010));
			end
		join
		idle(drain_cycles);
	endtask

	initial begin
		repeat (max_cycles) @(posedge clk156);
		$display("timeout after %0d cycles, the tests did not finish", max_cycles);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		rx0 = '0;
		rx1 = '0;
		db_reply = '0;
		eth_rst = 1'b1;
		repeat (3) @(posedge clk156);
		eth_rst <= 1'b0;
		test_pass_through();
		test_dns_response();
		test_icmp_unreach();
		test_block();
		test_priority();
		if (exp_req_q.size() != 0) begin
			fail_cnt++;
			$display("%0d expected database requests never arrived", exp_req_q.size());
		end
		fail_cnt = fail_cnt + dns_guard_top_i.dns_guard_asserts_i.fail_count;
		$display("error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/db_req_arbiter.sv
// registered merge of the two parser requests onto the database port, port 0 first
`default_nettype none

module db_req_arbiter (
	input  wire logic                         clk156,
	input  wire logic                         eth_rst,
	input  wire logic                         fire0,
	input  wire logic                         fire1,
	input  wire dns_guard_pkg::lookup_req_t   req0,
	input  wire dns_guard_pkg::lookup_req_t   req1,
	output logic                              db_req_valid,
	output dns_guard_pkg::lookup_req_t        db_req
);
	import dns_guard_pkg::*;

	lookup_req_t win_req;

	// port 1 loses when both fire together
	assign win_req = fire0 ? req0 : req1;

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			db_req_valid <= 1'b0;
		end else begin
			db_req_valid <= fire0 || fire1;
		end
	end

	// request payload only moves on a fire
	always_ff @(posedge clk156) begin
		if (fire0 || fire1) begin
			db_req <= win_req;
		end
	end

endmodule

`default_nettype wire

// File: hw/dns_guard_pkg.sv
// protocol constants, database op enum, beat, key, request and reply structs
`default_nettype none

package dns_guard_pkg;

	// ethernet and ip protocol numbers
	localparam logic [15:0] eth_type_ipv4 = 16'h0800;
	localparam logic [7:0]  ip_proto_udp  = 8'h11;
	localparam logic [7:0]  ip_proto_icmp = 8'h01;

	// icmp destination unreachable and the codes we act on
	localparam logic [7:0] icmp_dest_unreach      = 8'h03;
	localparam logic [7:0] icmp_code_port_unreach = 8'h03;
	localparam logic [7:0] icmp_code_admin_prohib = 8'h0a;

	// dns server ports, the debug one is for lab setups
	localparam logic [15:0] dns_std_port   = 16'd53;
	localparam logic [15:0] dns_debug_port = 16'd12345;

	// one 64-bit stream beat, frame byte 8k+j in lane j
	typedef struct packed {
		logic        tvalid;
		logic [63:0] tdata;
		logic [7:0]  tkeep;
		logic        tlast;
	} beat_t;

	typedef logic [9:0] beat_idx_t;

	// flow database opcodes
	typedef enum logic [3:0] {
		OP_NONE   = 4'b0000,
		OP_LOOKUP = 4'b0011,
		OP_INSERT = 4'b0101
	} db_op_e;

	// flow key, reserved field stays zero
	typedef struct packed {
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] dst_port;
		logic [15:0] rsvd;
	} lookup_key_t;

	typedef struct packed {
		db_op_e      op;
		lookup_key_t key;
	} lookup_req_t;

	// database reply, flag[2:1] carries the verdict
	typedef struct packed {
		logic       valid;
		logic [3:0] flag;
	} db_reply_t;

	localparam logic [1:0] verdict_block = 2'b10;

endpackage

`default_nettype wire

// File: hw/dns_guard_top.sv
// top level: two parsers, request arbiter and port 0 delay line
`default_nettype none

module dns_guard_top #(
	parameter logic [15:0] dns_port     = dns_guard_pkg::dns_std_port,
	parameter int unsigned delay_stages = 12
) (
	input  wire logic                         clk156,
	input  wire logic                         eth_rst,
	input  wire dns_guard_pkg::beat_t         rx0,
	input  wire dns_guard_pkg::beat_t         rx1,
	input  wire dns_guard_pkg::db_reply_t     db_reply,
	output logic                              db_req_valid,
	output dns_guard_pkg::lookup_req_t        db_req,
	output dns_guard_pkg::beat_t              tx
);
	import dns_guard_pkg::*;

	logic        fire0;
	logic        fire1;
	lookup_req_t req0;
	lookup_req_t req1;

	// network side, dns responses
	dns_resp_parser #(
		.dns_port (dns_port)
	) dns_resp_parser_i (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.rx      (rx0),
		.fire    (fire0),
		.req     (req0)
	);

	// icmp unreachable feedback
	icmp_unreach_parser #(
		.dns_port (dns_port)
	) icmp_unreach_parser_i (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.rx      (rx1),
		.fire    (fire1),
		.req     (req1)
	);

	db_req_arbiter db_req_arbiter_i (
		.clk156       (clk156),
		.eth_rst      (eth_rst),
		.fire0        (fire0),
		.fire1        (fire1),
		.req0         (req0),
		.req1         (req1),
		.db_req_valid (db_req_valid),
		.db_req       (db_req)
	);

	// port 0 waits here for the database verdict
	drop_delay_line #(
		.delay_stages (delay_stages)
	) drop_delay_line_i (
		.clk156   (clk156),
		.eth_rst  (eth_rst),
		.rx       (rx0),
		.db_reply (db_reply),
		.tx       (tx)
	);

endmodule

`default_nettype wire

// File: hw/dns_resp_parser.sv
// port 0 parser: beat index, header capture, dns server response detect, lookup request
`default_nettype none

module dns_resp_parser #(
	parameter logic [15:0] dns_port = dns_guard_pkg::dns_std_port
) (
	input  wire logic                         clk156,
	input  wire logic                         eth_rst,
	input  wire dns_guard_pkg::beat_t         rx,
	output logic                              fire,
	output dns_guard_pkg::lookup_req_t        req
);
	import dns_guard_pkg::*;

	beat_idx_t   idx;
	logic [15:0] eth_type;
	logic [7:0]  ip_proto;
	logic [31:0] src_ip;
	logic [31:0] dst_ip;
	logic [15:0] src_port;
	logic [15:0] dst_port;
	logic        dns_qr;
	logic        server_frame;

	// ipv4/udp sent from the dns server port
	assign server_frame = (eth_type == eth_type_ipv4) && (ip_proto == ip_proto_udp) &&
		(src_port == dns_port);

	// beat position, back to 0 after tlast
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			idx <= '0;
		end else if (rx.tvalid) begin
			if (rx.tlast) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// header fields, big endian across byte lanes
	always_ff @(posedge clk156) begin
		if (rx.tvalid) begin
			case (idx)
				10'd0: begin
					eth_type <= '0;
					ip_proto <= '0;
					src_ip   <= '0;
					dst_ip   <= '0;
					src_port <= '0;
					dst_port <= '0;
					dns_qr   <= 1'b0;
				end
				10'd1: eth_type <= {rx.tdata[39:32], rx.tdata[47:40]};
				10'd2: ip_proto <= rx.tdata[63:56];
				10'd3: begin
					src_ip <= {rx.tdata[23:16], rx.tdata[31:24],
						rx.tdata[39:32], rx.tdata[47:40]};
					dst_ip[31:16] <= {rx.tdata[55:48], rx.tdata[63:56]};
				end
				10'd4: begin
					dst_ip[15:0] <= {rx.tdata[7:0], rx.tdata[15:8]};
					// udp ports only make sense for ipv4/udp
					if (eth_type == eth_type_ipv4 && ip_proto == ip_proto_udp) begin
						src_port <= {rx.tdata[23:16], rx.tdata[31:24]};
						dst_port <= {rx.tdata[39:32], rx.tdata[47:40]};
					end
				end
				// qr is the top bit of frame byte 44
				10'd5: dns_qr <= rx.tdata[39];
				default: ;
			endcase
		end
	end

	assign fire = rx.tvalid && (idx == 10'd7) && server_frame;

	// responses get a lookup, queries go out as op none
	always_comb begin
		req.op           = dns_qr ? OP_LOOKUP : OP_NONE;
		req.key.src_ip   = src_ip;
		req.key.dst_ip   = dst_ip;
		req.key.dst_port = dst_port;
		req.key.rsvd     = '0;
	end

endmodule

`default_nettype wire

// File: hw/drop_delay_line.sv
// port 0 delay pipeline with block latch that erases beats on a block verdict
`default_nettype none

module drop_delay_line #(
	parameter int unsigned delay_stages = 12
) (
	input  wire logic                         clk156,
	input  wire logic                         eth_rst,
	input  wire dns_guard_pkg::beat_t         rx,
	input  wire dns_guard_pkg::db_reply_t     db_reply,
	output dns_guard_pkg::beat_t              tx
);
	import dns_guard_pkg::*;

	beat_t stage [delay_stages];
	logic  in_frame;
	logic  sof;
	logic  block_reply;
	logic  block_latch;
	logic  block;

	assign block_reply = db_reply.valid && (db_reply.flag[2:1] == verdict_block);
	assign block       = block_reply || block_latch;

	// frame start seen on our own input
	assign sof = rx.tvalid && !in_frame;

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			in_frame <= 1'b0;
		end else if (rx.tvalid) begin
			in_frame <= !rx.tlast;
		end
	end

	// block holds until the next frame starts
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			block_latch <= 1'b0;
		end else if (sof) begin
			block_latch <= 1'b0;
		end else if (block_reply) begin
			block_latch <= 1'b1;
		end
	end

	// stage 0 always loads, the rest are wiped while blocking
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			for (int i = 0; i < delay_stages; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= rx;
			for (int i = 1; i < delay_stages; i++) begin
				stage[i] <= block ? '0 : stage[i-1];
			end
		end
	end

	assign tx = stage[delay_stages-1];

endmodule

`default_nettype wire

// File: hw/icmp_unreach_parser.sv
// port 1 parser: beat index, icmp unreachable check, quoted ip/udp capture, insert request
`default_nettype none

module icmp_unreach_parser #(
	parameter logic [15:0] dns_port = dns_guard_pkg::dns_std_port
) (
	input  wire logic                         clk156,
	input  wire logic                         eth_rst,
	input  wire dns_guard_pkg::beat_t         rx,
	output logic                              fire,
	output dns_guard_pkg::lookup_req_t        req
);
	import dns_guard_pkg::*;

	beat_idx_t   idx;
	logic [15:0] eth_type;
	logic [7:0]  ip_proto;
	logic [7:0]  icmp_type;
	logic [7:0]  icmp_code;
	logic [31:0] q_src_ip;
	logic [31:0] q_dst_ip;
	logic [15:0] q_src_port;
	logic [15:0] q_dst_port;
	logic        unreach_frame;
	logic        code_ok;

	assign code_ok = (icmp_code == icmp_code_port_unreach) ||
		(icmp_code == icmp_code_admin_prohib);

	assign unreach_frame = (eth_type == eth_type_ipv4) && (ip_proto == ip_proto_icmp) &&
		(icmp_type == icmp_dest_unreach) && code_ok;

	// beat position, back to 0 after tlast
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			idx <= '0;
		end else if (rx.tvalid) begin
			if (rx.tlast) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// outer headers and the quoted ip/udp header
	always_ff @(posedge clk156) begin
		if (rx.tvalid) begin
			case (idx)
				10'd0: begin
					eth_type   <= '0;
					ip_proto   <= '0;
					icmp_type  <= '0;
					icmp_code  <= '0;
					q_src_ip   <= '0;
					q_dst_ip   <= '0;
					q_src_port <= '0;
					q_dst_port <= '0;
				end
				10'd1: eth_type <= {rx.tdata[39:32], rx.tdata[47:40]};
				10'd2: ip_proto <= rx.tdata[63:56];
				// icmp type and code in bytes 34, 35
				10'd4: begin
					icmp_type <= rx.tdata[23:16];
					icmp_code <= rx.tdata[31:24];
				end
				// quoted source ip straddles beats 6 and 7
				10'd6: q_src_ip[31:16] <= {rx.tdata[55:48], rx.tdata[63:56]};
				10'd7: begin
					q_src_ip[15:0] <= {rx.tdata[7:0], rx.tdata[15:8]};
					q_dst_ip <= {rx.tdata[23:16], rx.tdata[31:24],
						rx.tdata[39:32], rx.tdata[47:40]};
					q_src_port <= {rx.tdata[55:48], rx.tdata[63:56]};
				end
				10'd8: q_dst_port <= {rx.tdata[7:0], rx.tdata[15:8]};
				default: ;
			endcase
		end
	end

	// quoted packet was a reply from the dns server port
	assign fire = rx.tvalid && (idx == 10'd11) && unreach_frame &&
		(q_src_port == dns_port);

	always_comb begin
		req.op           = OP_INSERT;
		req.key.src_ip   = q_src_ip;
		req.key.dst_ip   = q_dst_ip;
		req.key.dst_port = q_dst_port;
		req.key.rsvd     = '0;
	end

endmodule

`default_nettype wire

// File: tb.f
hw/dns_guard_pkg.sv
hw/dns_resp_parser.sv
hw/icmp_unreach_parser.sv
hw/db_req_arbiter.sv
hw/drop_delay_line.sv
hw/dns_guard_top.sv
dv/dns_guard_asserts.sv
dv/dns_guard_tb.sv
